// ==== Bender.yml ====
package:
  name: audio_loop

sources:
  # RTL in compile order
  - include_dirs:
      - source
    files:
      - source/audio_pkg.sv
      - source/audio_sample_if.sv
      - source/i2s_mic_receiver.sv
      - source/sound_gain_stage.sv
      - source/i2s_audio_transmitter.sv
      - source/audio_board_top.sv
  # Testbench
  - target: test
    include_dirs:
      - source
    files:
      - verif/audio_tb.sv

// ==== audio_loop.f ====
+incdir+source
source/audio_pkg.sv
source/audio_sample_if.sv
source/i2s_mic_receiver.sv
source/sound_gain_stage.sv
source/i2s_audio_transmitter.sv
source/audio_board_top.sv
verif/audio_tb.sv

// ==== source/audio_board_top.sv ====
`timescale 1ns/1ps
`include "audio_defs.svh"

module audio_board_top
(
    input  logic       clk,
    input  logic       rst,
    input  logic [1:0] sw,         // Gain opcode
    input  logic       mic_sd,
    output logic       mic_sck,
    output logic       mic_ws,
    output logic       mic_lr,
    output logic       dac_bclk,
    output logic       dac_lrclk,
    output logic       dac_sdata,
    output logic [7:0] led         // Overrun and clip count
);
    import audio_pkg::*;

    logic                    overrun;
    logic [`CLIP_CNT_W - 1:0] clip_count;

    // ------------------------------------------------------------
    // Inter-stage links
    // ------------------------------------------------------------

    audio_sample_if #(.W(`W_MIC)) mic_link ();  // Receiver to gain
    audio_sample_if               snd_link ();  // Gain to DAC

    // ------------------------------------------------------------
    // Pipeline
    // ------------------------------------------------------------

    i2s_mic_receiver i_mic_receiver
    (
        .clk     ( clk      ),
        .rst     ( rst      ),
        .sd      ( mic_sd   ),
        .sck     ( mic_sck  ),
        .ws      ( mic_ws   ),
        .lr      ( mic_lr   ),
        .overrun ( overrun  ),
        .out     ( mic_link )
    );

    sound_gain_stage i_gain_stage
    (
        .clk        ( clk             ),
        .rst        ( rst             ),
        .op         ( gain_op_e'(sw)  ),
        .in         ( mic_link        ),
        .out        ( snd_link        ),
        .clip_count ( clip_count      )
    );

    i2s_audio_transmitter i_audio_transmitter
    (
        .clk   ( clk       ),
        .rst   ( rst       ),
        .in    ( snd_link  ),
        .bclk  ( dac_bclk  ),
        .lrclk ( dac_lrclk ),
        .sdata ( dac_sdata )
    );

    assign led = {overrun, clip_count};  // led[7] overrun, led[6:0] clips

endmodule

// ==== source/audio_defs.svh ====
`ifndef AUDIO_DEFS_SVH
`define AUDIO_DEFS_SVH

// ------------------------------------------------------------
// Sample widths
// ------------------------------------------------------------

`define W_MIC       24  // INMP441 word
`define W_SOUND     16  // DAC word

// ------------------------------------------------------------
// Serial timing
// ------------------------------------------------------------

`define SCK_DIV     4   // System clocks per half sck or bclk
`define SLOT_BITS   32  // Bit clocks in one channel slot

`define CLIP_CNT_W  7   // Clip counter, shown on led[6:0]

`endif

// ==== source/audio_pkg.sv ====
`include "audio_defs.svh"

package audio_pkg;

    // ------------------------------------------------------------
    // Sample words
    // ------------------------------------------------------------

    typedef logic signed [`W_MIC   - 1:0] mic_sample_t;    // Raw microphone word
    typedef logic signed [`W_SOUND - 1:0] sound_sample_t;  // Word sent to the DAC

    // Gain selection, taken from sw[1:0]
    typedef enum logic [1:0]
    {
        op_pass  = 2'd0,  // Top 16 bits
        op_boost = 2'd1,  // x4 with saturation
        op_cut   = 2'd2,  // Arithmetic /4
        op_mute  = 2'd3   // Silence
    } gain_op_e;

    // ------------------------------------------------------------
    // FSM states
    // ------------------------------------------------------------

    typedef enum logic [1:0] {idle_slot, shift_in, offer} rx_state_e;

    typedef enum logic [1:0] {wait_edge, delay_bit, shift_out, pad} tx_state_e;

    // Source side of a four-phase link
    typedef enum logic [1:0] {idle, wait_ack, wait_release} link_state_e;

endpackage

// ==== source/audio_sample_if.sv ====
`timescale 1ns/1ps
`include "audio_defs.svh"

// One sample between two pipeline stages, four-phase req/ack
interface audio_sample_if
#(
    parameter int W = `W_SOUND  // Mic width on the first link
);

    logic         req;    // Source has a word
    logic         ack;    // Sink took it
    logic [W-1:0] data;   // Held while req is high
    logic         right;  // Channel flag, 1 for right

    modport source
    (
        output req,
        output data,
        output right,
        input  ack
    );

    modport sink
    (
        input  req,
        input  data,
        input  right,
        output ack
    );

endinterface

// ==== source/i2s_audio_transmitter.sv ====
`timescale 1ns/1ps
`include "audio_defs.svh"

module i2s_audio_transmitter
(
    input  logic         clk,
    input  logic         rst,
    audio_sample_if.sink in,
    output logic         bclk,
    output logic         lrclk,
    output logic         sdata
);
    import audio_pkg::*;

    localparam int                 div_w     = $clog2(`SCK_DIV);
    localparam int                 pos_w     = $clog2(`SLOT_BITS);
    localparam logic [div_w - 1:0] div_last  = div_w'(`SCK_DIV - 1);
    localparam logic [pos_w - 1:0] slot_last = pos_w'(`SLOT_BITS - 1);
    localparam logic [pos_w - 1:0] data_end  = pos_w'(`W_SOUND);  // Last data bit done

    logic [div_w - 1:0] div_cnt;
    logic [pos_w    :0] frame_cnt;
    logic               bclk_fall;
    logic               slot_edge;   // lrclk about to toggle
    logic               load_ch;     // Channel of the starting slot
    logic               accept;
    logic [1:0]         pend_valid;  // Index 1 is right
    sound_sample_t      pend_data [2];
    sound_sample_t      shreg;
    tx_state_e          state;

    // ------------------------------------------------------------
    // bclk and lrclk
    // ------------------------------------------------------------

    assign bclk_fall = (div_cnt == div_last) && bclk;
    assign slot_edge = bclk_fall && (frame_cnt[pos_w - 1:0] == slot_last);
    assign load_ch   = ~frame_cnt[pos_w];
    assign lrclk     = frame_cnt[pos_w];  // Low is left

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            div_cnt   <= '0;
            bclk      <= 1'b0;
            frame_cnt <= '0;
        end
        else
        begin
            if (div_cnt == div_last)
            begin
                div_cnt <= '0;
                bclk    <= ~bclk;
            end
            else
                div_cnt <= div_cnt + 1'b1;

            if (bclk_fall)
                frame_cnt <= frame_cnt + 1'b1;
        end
    end

    // ------------------------------------------------------------
    // Pending words, one per channel
    // ------------------------------------------------------------

    assign accept = in.req && !in.ack && !pend_valid[in.right];

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            in.ack     <= 1'b0;
            pend_valid <= '0;
        end
        else
        begin
            if (slot_edge)
                pend_valid[load_ch] <= 1'b0;  // Moved to the shifter
            if (accept)
            begin
                in.ack              <= 1'b1;
                pend_valid[in.right] <= 1'b1;  // Goes out in the next slot
            end
            else if (in.ack && !in.req)
                in.ack <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
            pend_data[in.right] <= in.data;
    end

    // ------------------------------------------------------------
    // Serializer
    // ------------------------------------------------------------

    always_ff @(posedge clk)
    begin
        if (slot_edge)
            shreg <= pend_valid[load_ch] ? pend_data[load_ch] : '0;  // Zero if empty
        else if (bclk_fall && (state == delay_bit || state == shift_out))
            shreg <= shreg << 1;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state <= wait_edge;
            sdata <= 1'b0;
        end
        else
        begin
            case (state)
                wait_edge: if (slot_edge) state <= delay_bit;  // First full slot
                delay_bit:
                    if (bclk_fall)
                    begin
                        sdata <= shreg[`W_SOUND - 1];  // MSB one bclk after lrclk
                        state <= shift_out;
                    end
                shift_out:
                    if (bclk_fall)
                    begin
                        if (frame_cnt[pos_w - 1:0] == data_end)
                        begin
                            sdata <= 1'b0;
                            state <= pad;
                        end
                        else
                            sdata <= shreg[`W_SOUND - 1];
                    end
                pad:       if (slot_edge) state <= delay_bit;
                default:   state <= wait_edge;
            endcase
        end
    end

    ack_follows_release: assert property (@(posedge clk) disable iff (rst)
        (in.ack && !in.req) |=> !(in.ack && !in.req))
        else $error("snd link ack held after req release");

endmodule

// ==== source/i2s_mic_receiver.sv ====
`timescale 1ns/1ps
`include "audio_defs.svh"

module i2s_mic_receiver
(
    input  logic           clk,
    input  logic           rst,
    input  logic           sd,       // Shared data line of both mics
    output logic           sck,
    output logic           ws,
    output logic           lr,
    output logic           overrun,  // Sticky, word dropped
    audio_sample_if.source out
);
    import audio_pkg::*;

    localparam int                 div_w     = $clog2(`SCK_DIV);
    localparam int                 pos_w     = $clog2(`SLOT_BITS);
    localparam logic [div_w - 1:0] div_last  = div_w'(`SCK_DIV - 1);
    localparam logic [pos_w - 1:0] first_bit = pos_w'(1);       // MSB on 2nd rising edge
    localparam logic [pos_w - 1:0] last_bit  = pos_w'(`W_MIC);  // 24th bit

    logic [div_w - 1:0] div_cnt;
    logic [pos_w    :0] frame_cnt;  // Upper bit is the slot
    logic [pos_w - 1:0] slot_pos;
    logic               sck_rise;
    logic               sck_fall;
    logic               shift_en;
    rx_state_e          state;
    link_state_e        link;
    mic_sample_t        shreg;

    // ------------------------------------------------------------
    // sck and ws generation
    // ------------------------------------------------------------

    assign sck_rise = (div_cnt == div_last) && !sck;  // sck about to rise
    assign sck_fall = (div_cnt == div_last) && sck;
    assign slot_pos = frame_cnt[pos_w - 1:0];
    assign ws       = frame_cnt[pos_w];               // Low is left slot
    assign lr       = 1'b0;                           // This mic answers when ws is low

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            div_cnt   <= '0;
            sck       <= 1'b0;
            frame_cnt <= '0;
        end
        else
        begin
            if (div_cnt == div_last)
            begin
                div_cnt <= '0;
                sck     <= ~sck;
            end
            else
                div_cnt <= div_cnt + 1'b1;

            if (sck_fall)
                frame_cnt <= frame_cnt + 1'b1;  // ws changes with falling sck
        end
    end

    // ------------------------------------------------------------
    // Deserializer
    // ------------------------------------------------------------

    assign shift_en = sck_rise
                    && ((state == idle_slot && slot_pos == first_bit) || state == shift_in);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            state <= idle_slot;
        else
        begin
            case (state)
                idle_slot: if (sck_rise && slot_pos == first_bit) state <= shift_in;
                shift_in:  if (sck_rise && slot_pos == last_bit)  state <= offer;
                offer:     state <= idle_slot;  // One clock to hand over
                default:   state <= idle_slot;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (shift_en)
            shreg <= {shreg[`W_MIC - 2:0], sd};  // MSB first
    end

    // ------------------------------------------------------------
    // Downstream link
    // ------------------------------------------------------------

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            link    <= idle;
            out.req <= 1'b0;
            overrun <= 1'b0;
        end
        else
        begin
            case (link)
                idle:
                    if (state == offer)
                    begin
                        out.req <= 1'b1;
                        link    <= wait_ack;
                    end
                wait_ack:
                    if (out.ack)
                    begin
                        out.req <= 1'b0;
                        link    <= wait_release;
                    end
                wait_release:
                    if (!out.ack) link <= idle;  // Sink released, link free
                default:
                    link <= idle;
            endcase

            if (state == offer && link != idle)
                overrun <= 1'b1;  // Previous word still pending, new one lost
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == offer && link == idle)
        begin
            out.data  <= shreg;
            out.right <= ws;  // Still inside the word's slot
        end
    end

    req_held_until_ack: assert property (@(posedge clk) disable iff (rst)
        out.req && !out.ack |=> out.req)
        else $error("mic link req dropped before ack");

endmodule

// ==== source/sound_gain_stage.sv ====
`timescale 1ns/1ps
`include "audio_defs.svh"

module sound_gain_stage
(
    input  logic                      clk,
    input  logic                      rst,
    input  audio_pkg::gain_op_e       op,
    audio_sample_if.sink              in,
    audio_sample_if.source            out,
    output logic [`CLIP_CNT_W - 1:0]  clip_count
);
    import audio_pkg::*;

    logic          full;       // Holding a captured word
    logic          take;       // Accept the word on the input link
    logic          launch;     // Forward the result downstream
    mic_sample_t   smp;
    logic          smp_right;
    gain_op_e      op_q;       // Opcode latched with the sample
    link_state_e   link;
    sound_sample_t gained;
    logic          clipped;
    logic [2:0]    top3;       // Bits lost by x4

    // ------------------------------------------------------------
    // Gain datapath
    // ------------------------------------------------------------

    assign top3 = smp[`W_MIC - 1 -: 3];

    always_comb
    begin
        gained  = '0;
        clipped = 1'b0;
        case (op_q)
            op_pass:
                gained = smp[`W_MIC - 1 -: `W_SOUND];
            op_boost:
                if (top3 == 3'b000 || top3 == 3'b111)
                    gained = smp[`W_MIC - 3 -: `W_SOUND];  // Fits after x4
                else
                begin
                    gained  = {smp[`W_MIC - 1], {(`W_SOUND - 1){~smp[`W_MIC - 1]}}};
                    clipped = 1'b1;  // Full scale of the input sign
                end
            op_cut:
                gained = {{2{smp[`W_MIC - 1]}}, smp[`W_MIC - 1 -: `W_SOUND - 2]};
            default:
                gained = '0;  // Mute
        endcase
    end

    // ------------------------------------------------------------
    // Input link
    // ------------------------------------------------------------

    assign take   = in.req && !in.ack && !full;     // Stalls while a word waits
    assign launch = (link == idle) && full && !in.ack;  // Only after release

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            in.ack <= 1'b0;
            full   <= 1'b0;
        end
        else
        begin
            if (take)
            begin
                in.ack <= 1'b1;
                full   <= 1'b1;
            end
            else if (in.ack && !in.req)
                in.ack <= 1'b0;  // Release done

            if (launch)
                full <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (take)
        begin
            smp       <= in.data;
            smp_right <= in.right;
            op_q      <= op;  // sw sampled at accept
        end
    end

    // ------------------------------------------------------------
    // Output link and clip counter
    // ------------------------------------------------------------

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            link       <= idle;
            out.req    <= 1'b0;
            clip_count <= '0;
        end
        else
        begin
            case (link)
                idle:
                    if (launch)
                    begin
                        out.req <= 1'b1;
                        link    <= wait_ack;
                        if (clipped && clip_count != '1)
                            clip_count <= clip_count + 1'b1;  // Holds at max
                    end
                wait_ack:
                    if (out.ack)
                    begin
                        out.req <= 1'b0;
                        link    <= wait_release;
                    end
                wait_release:
                    if (!out.ack) link <= idle;
                default:
                    link <= idle;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (launch)
        begin
            out.data  <= gained;
            out.right <= smp_right;
        end
    end

    snd_data_stable: assert property (@(posedge clk) disable iff (rst)
        out.req |=> !out.req || ($stable(out.data) && $stable(out.right)))
        else $error("gain output changed while req high");

endmodule

// ==== verif/audio_input.txt ====
# id sw left right exp_left exp_right
# sw: 0 pass, 1 boost x4, 2 cut /4, 3 mute; mic words 24-bit hex, outputs 16-bit hex
pass_a 0 123456 FEDCBA 1234 FEDC
pass_b 0 7FFFFF 800000 7FFF 8000
pass_c 0 00ABCD F0F0F0 00AB F0F0
pass_d 0 3C5A96 C3A569 3C5A C3A5
boost_a 1 012345 FF0000 048D FC00
boost_sat1 1 400000 B00000 7FFF 8000
boost_sat2 1 7FFFFF 800000 7FFF 8000
boost_b 1 1FFFC0 E00040 7FFF 8001
boost_sat3 1 200000 DFFFFF 7FFF 8000
cut_a 2 123456 FEDCBA 048D FFB7
cut_b 2 7FFFFF 800000 1FFF E000
cut_c 2 000400 FFFC00 0001 FFFF
mute_a 3 123456 FEDCBA 0000 0000
mute_b 3 7FFFFF 800000 0000 0000
pass_e 0 000100 FFFF00 0001 FFFF
pass_f 0 5A5A5A A5A5A5 5A5A A5A5

// ==== verif/audio_tb.sv ====
`timescale 1ns/1ps
`include "audio_defs.svh"

module audio_tb;
    import audio_pkg::*;

    localparam int max_vec   = 64;
    localparam int fill_size = 256;  // Random slot fills, reused cyclically

    logic       clk;
    logic       rst;
    logic [1:0] sw;
    logic       mic_sd;
    logic       mic_sck;
    logic       mic_ws;
    logic       mic_lr;
    logic       dac_bclk;
    logic       dac_lrclk;
    logic       dac_sdata;
    logic [7:0] led;

    string         vec_name  [max_vec];  // Vectors from the data file
    gain_op_e      vec_op    [max_vec];
    mic_sample_t   vec_left  [max_vec];
    mic_sample_t   vec_right [max_vec];
    sound_sample_t exp_left  [max_vec];
    sound_sample_t exp_right [max_vec];
    int            n_vec;
    logic [31:0]   fill_bits [fill_size];  // Bits after the 24th of each slot

    int            errors;
    int            checks;
    int            cycle_limit;

    int            mic_cnt;    // sck falls since reset, mirrors the receiver
    int            slot_idx;
    int            slot_pos;
    logic          sck_prev;
    mic_sample_t   cur_left;
    mic_sample_t   cur_right;
    mic_sample_t   cur_word;

    int            dac_cnt;    // bclk falls since reset
    sound_sample_t dac_word;
    sound_sample_t dac_left  [$];  // One word per decoded slot
    sound_sample_t dac_right [$];

    audio_board_top uut
    (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .sw        ( sw        ),
        .mic_sd    ( mic_sd    ),
        .mic_sck   ( mic_sck   ),
        .mic_ws    ( mic_ws    ),
        .mic_lr    ( mic_lr    ),
        .dac_bclk  ( dac_bclk  ),
        .dac_lrclk ( dac_lrclk ),
        .dac_sdata ( dac_sdata ),
        .led       ( led       )
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 100 MHz
    end

    // ------------------------------------------------------------
    // Compare tasks and helpers
    // ------------------------------------------------------------

    task automatic check_sample(input string name, input sound_sample_t expected,
                                input sound_sample_t actual);
        checks++;
        if (actual !== expected)
        begin
            $display("Fail %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_led(input string name, input logic [7:0] expected,
                             input logic [7:0] actual);
        checks++;
        if (actual !== expected)
        begin
            $display("Fail %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        checks++;
        if (actual != expected)
        begin
            $display("Fail %s expected %0d actual %0d", name, expected, actual);
            errors++;
        end
    endtask

    // x4 then keep the top 16 of 24 bits, clipped if outside the 16-bit range
    function automatic bit boost_saturates(input mic_sample_t x);
        longint scaled;
        scaled = longint'(x) * 4;
        scaled = scaled >>> (`W_MIC - `W_SOUND);
        return (scaled > 32767) || (scaled < -32768);
    endfunction

    task automatic load_frame(input int frame);
        int v;
        v = frame - 1;  // Frame 0 is idle
        if (v < n_vec)
        begin
            cur_left  = vec_left[v];
            cur_right = vec_right[v];
            sw        = vec_op[v];  // Gain for this frame's two words
        end
        else
        begin
            cur_left  = '0;  // Flush frames
            cur_right = '0;
        end
    endtask

    // ------------------------------------------------------------
    // Microphone pair on the shared data line
    // ------------------------------------------------------------

    always @(negedge clk)
    begin
        if (rst)
        begin
            mic_cnt   = 0;
            sck_prev  = 1'b0;
            cur_left  = '0;
            cur_right = '0;
        end
        else
        begin
            if (sck_prev && !mic_sck)  // sck fell, set up the next bit
            begin
                mic_cnt  = mic_cnt + 1;
                slot_idx = mic_cnt / `SLOT_BITS;
                slot_pos = mic_cnt % `SLOT_BITS;
                if (mic_cnt % (2 * `SLOT_BITS) == 0)
                    load_frame(mic_cnt / (2 * `SLOT_BITS));  // ws just fell
                if (mic_ws !== slot_idx[0])
                begin
                    $display("mic_ws is out of step with the sck count in slot %0d", slot_idx);
                    errors++;
                end
                if (mic_lr !== 1'b0)
                begin
                    $display("mic_lr is not low, the mic pair would answer in swapped slots");
                    errors++;
                end
                cur_word = slot_idx[0] ? cur_right : cur_left;  // ws high is right
                if (slot_pos >= 1 && slot_pos <= `W_MIC)
                    mic_sd = cur_word[`W_MIC - slot_pos];  // MSB first
                else
                    mic_sd = fill_bits[slot_idx % fill_size][slot_pos];
            end
            sck_prev = mic_sck;
        end
    end

    // ------------------------------------------------------------
    // DAC stream decoder
    // ------------------------------------------------------------

    always @(negedge dac_bclk)
    begin
        if (rst === 1'b0)
            dac_cnt = dac_cnt + 1;
    end

    always @(posedge dac_bclk)
    begin
        if (rst === 1'b0)
        begin
            if (dac_lrclk !== ((dac_cnt / `SLOT_BITS) % 2 == 1))  // Low is left
            begin
                $display("dac_lrclk is out of step with the bclk count in slot %0d",
                         dac_cnt / `SLOT_BITS);
                errors++;
            end
            if (dac_cnt % `SLOT_BITS >= 1 && dac_cnt % `SLOT_BITS <= `W_SOUND)
            begin
                dac_word = {dac_word[`W_SOUND - 2:0], dac_sdata};
                if (dac_cnt % `SLOT_BITS == `W_SOUND)  // Last data bit of the slot
                begin
                    if ((dac_cnt / `SLOT_BITS) % 2 == 1)
                        dac_right.push_back(dac_word);
                    else
                        dac_left.push_back(dac_word);
                end
            end
            else if (dac_sdata !== 1'b0)  // Padding bits
            begin
                $display("dac_sdata is not zero outside the data bits of slot %0d",
                         dac_cnt / `SLOT_BITS);
                errors++;
            end
        end
    end

    initial
    begin
        int cycle_cnt;
        cycle_cnt = 0;
        wait (cycle_limit > 0);
        while (cycle_cnt < cycle_limit)
        begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout after %0d cycles, DAC words missing: left %0d of %0d, right %0d of %0d",
                 cycle_cnt, dac_left.size(), n_vec + 2, dac_right.size(), n_vec + 2);
        $display("sim failed");
        $finish;
    end

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------

    initial
    begin
        int           fd;
        int           n_tok;
        int           sw_val;
        int           i;
        int           clip_exp;
        int           nz_exp_left;
        int           nz_exp_right;
        int           nz_left;
        int           nz_right;
        int           errors_before;
        logic [127:0] tok;
        logic [1023:0] line_buf;
        logic [6:0]   clip_led;

        rst         = 1'b1;
        sw          = 2'b00;
        mic_sd      = 1'b0;
        n_vec       = 0;
        errors      = 0;
        checks      = 0;
        cycle_limit = 0;
        dac_cnt     = 0;
        void'($urandom(32'h2f0c9056));
        for (i = 0; i < fill_size; i++)
            fill_bits[i] = $urandom();

        repeat (4) @(negedge clk);
        rst = 1'b0;

        fd = $fopen("verif/audio_input.txt", "r");
        if (fd == 0)
        begin
            $display("Cannot open verif/audio_input.txt");
            errors++;
        end
        else
        begin
            while (!$feof(fd) && n_vec < max_vec)
            begin
                n_tok = $fscanf(fd, "%s", tok);
                if (n_tok == 1 && tok == "#")
                    void'($fgets(line_buf, fd));  // Column notes
                else if (n_tok == 1)
                begin
                    n_tok = $fscanf(fd, "%d %h %h %h %h", sw_val, vec_left[n_vec],
                                    vec_right[n_vec], exp_left[n_vec], exp_right[n_vec]);
                    if (n_tok == 5)
                    begin
                        vec_name[n_vec] = string'(tok);
                        vec_op[n_vec]   = gain_op_e'(sw_val[1:0]);
                        n_vec++;
                    end
                    else
                    begin
                        $display("Malformed vector line after %0d vectors", n_vec);
                        errors++;
                    end
                end
            end
            $fclose(fd);
        end
        if (n_vec == 0)
        begin
            $display("No test vectors were read");
            errors++;
        end

        clip_exp     = 0;
        nz_exp_left  = 0;
        nz_exp_right = 0;
        for (i = 0; i < n_vec; i++)
        begin
            if (vec_op[i] == op_boost)
                clip_exp += boost_saturates(vec_left[i]) + boost_saturates(vec_right[i]);
            nz_exp_left  += (exp_left[i] != 0);
            nz_exp_right += (exp_right[i] != 0);
        end
        cycle_limit = (n_vec + 4) * 64 * 2 * `SCK_DIV * 2;

        // Vector i is sent in mic frame i + 1 and comes back in DAC frame i + 2
        while (dac_left.size() < n_vec + 2 || dac_right.size() < n_vec + 2)
            @(negedge clk);

        for (i = 0; i < n_vec; i++)
        begin
            errors_before = errors;
            check_sample({vec_name[i], " left"}, exp_left[i], dac_left[i + 2]);
            check_sample({vec_name[i], " right"}, exp_right[i], dac_right[i + 2]);
            if (errors == errors_before)
                $display("Test %s ok", vec_name[i]);
            else
                $display("Test %s had %0d errors", vec_name[i], errors - errors_before);
        end

        @(negedge clk);
        errors_before = errors;
        nz_left       = 0;
        nz_right      = 0;
        for (i = 0; i < dac_left.size(); i++)
            nz_left += (dac_left[i] != 0);
        for (i = 0; i < dac_right.size(); i++)
            nz_right += (dac_right[i] != 0);
        clip_led = (clip_exp > 127) ? 7'h7f : clip_exp[6:0];  // Counter holds at max
        check_led("led_final", {1'b0, clip_led}, led);       // No overrun
        check_count("nonzero_left", nz_exp_left, nz_left);
        check_count("nonzero_right", nz_exp_right, nz_right);
        if (errors == errors_before)
            $display("Test totals ok");
        else
            $display("Test totals had %0d errors", errors - errors_before);

        $display("Tests %0d, checks %0d, errors %0d", n_vec + 1, checks, errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule
